// File: source/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int WAY_W          = 2;
    localparam int INDEX_W        = 4;
    localparam int OFFSET_W       = 4;
    localparam int TAG_W          = 32 - INDEX_W - OFFSET_W;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 1 << INDEX_W;

    // CPU address split
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL
    } ctrl_state_t;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;

    // Word 0 in the low bits
    typedef logic [3:0][31:0] line_t;

    // Cache to memory
    typedef struct packed {
        logic        rd_req;
        logic [31:0] rd_addr;
    } refill_req_t;

    // Memory to cache, whole line in one beat
    typedef struct packed {
        logic  ret_valid;
        line_t ret_data;
    } refill_ret_t;

endpackage

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           valid,
    input  icache_pkg::cache_addr_t        req,
    input  logic [icache_pkg::NUM_WAYS-1:0] hit_way,
    input  logic                           rd_rdy,
    input  mem_pkg::refill_ret_t           mem_ret,
    output logic                           addr_ok,
    output logic                           data_ok,
    output mem_pkg::refill_req_t           mem_req,
    output logic [icache_pkg::TAG_W-1:0]    rb_tag,
    output logic [icache_pkg::INDEX_W-1:0]  rb_index,
    output logic [icache_pkg::OFFSET_W-1:0] rb_offset,
    output logic                           lookup_rd,
    output logic                           refill_we,
    output logic                           hit_touch,
    output logic                           miss_pick,
    output logic                           fill_touch
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t next_state;
    logic                    cache_hit;

    assign cache_hit = |hit_way;

    assign addr_ok = valid && ((state == icache_pkg::IDLE) ||
                               (state == icache_pkg::LOOKUP && cache_hit));
    assign lookup_rd = valid && addr_ok;

    assign hit_touch  = (state == icache_pkg::LOOKUP) && cache_hit;
    assign miss_pick  = (state == icache_pkg::LOOKUP) && !cache_hit;
    assign fill_touch = (state == icache_pkg::REPLACE);
    assign refill_we  = (state == icache_pkg::REFILL) && mem_ret.ret_valid;

    // Hit word comes from the arrays, miss word straight from the bus
    assign data_ok = hit_touch || refill_we;

    assign mem_req.rd_req  = (state == icache_pkg::REPLACE);
    assign mem_req.rd_addr = {rb_tag, rb_index, {icache_pkg::OFFSET_W{1'b0}}};

    // Request buffer
    always_ff @(posedge clk) begin
        if (lookup_rd) begin
            rb_tag    <= req.tag;
            rb_index  <= req.index;
            rb_offset <= req.offset;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (lookup_rd) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (!cache_hit) begin
                    next_state = icache_pkg::REPLACE;
                end else if (!lookup_rd) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            icache_pkg::REPLACE: begin
                if (rd_rdy) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (mem_ret.ret_valid) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            default: next_state = icache_pkg::IDLE;
        endcase
    end

endmodule

// File: source/tag_store.sv
`timescale 1ns/1ps

module tag_store (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            lookup_rd,
    input  logic                            refill_we,
    input  logic [icache_pkg::INDEX_W-1:0]  req_index,
    input  logic [icache_pkg::INDEX_W-1:0]  rb_index,
    input  logic [icache_pkg::TAG_W-1:0]    rb_tag,
    input  logic [icache_pkg::WAY_W-1:0]    victim,
    output logic [icache_pkg::NUM_WAYS-1:0] hit_way
);

    logic [icache_pkg::NUM_WAYS-1:0]                          victim_oh;
    logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::NUM_SETS-1:0] valid_q;

    assign victim_oh = {{(icache_pkg::NUM_WAYS-1){1'b0}}, 1'b1} << victim;

    // Valid bits live in flops so reset can clear them
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
        end else if (refill_we) begin
            valid_q[victim][rb_index] <= 1'b1;
        end
    end

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_way
        logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::NUM_SETS];
        logic [icache_pkg::TAG_W-1:0] tag_q;

        always_ff @(posedge clk) begin
            if (refill_we && victim_oh[w]) begin
                tag_mem[rb_index] <= rb_tag;
            end
            if (lookup_rd) begin
                tag_q <= tag_mem[req_index];
            end
        end

        // Compare against the buffered request
        assign hit_way[w] = valid_q[w][rb_index] && (tag_q == rb_tag);
    end

endmodule

// File: source/data_store.sv
`timescale 1ns/1ps

module data_store (
    input  logic                            clk,
    input  logic                            lookup_rd,
    input  logic                            refill_we,
    input  logic [icache_pkg::INDEX_W-1:0]  req_index,
    input  logic [icache_pkg::INDEX_W-1:0]  rb_index,
    input  logic [icache_pkg::OFFSET_W-1:0] rb_offset,
    input  logic [icache_pkg::NUM_WAYS-1:0] hit_way,
    input  logic [icache_pkg::WAY_W-1:0]    victim,
    input  mem_pkg::line_t                  ret_data,
    output mem_pkg::word_t                  rdata
);

    logic [icache_pkg::NUM_WAYS-1:0]             victim_oh;
    mem_pkg::line_t                              line_q [icache_pkg::NUM_WAYS];
    mem_pkg::line_t                              hit_line;
    logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] word_sel;

    assign victim_oh = {{(icache_pkg::NUM_WAYS-1){1'b0}}, 1'b1} << victim;

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_way
        mem_pkg::line_t line_mem [icache_pkg::NUM_SETS];

        always_ff @(posedge clk) begin
            if (refill_we && victim_oh[w]) begin
                line_mem[rb_index] <= ret_data;
            end
            if (lookup_rd) begin
                line_q[w] <= line_mem[req_index];
            end
        end
    end

    // hit_way is one-hot or zero
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_line = hit_line | line_q[w];
            end
        end
    end

    assign word_sel = rb_offset[icache_pkg::OFFSET_W-1:2];
    assign rdata    = refill_we ? ret_data[word_sel] : hit_line[word_sel];

endmodule

// File: source/plru_repl.sv
`timescale 1ns/1ps

module plru_repl (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [icache_pkg::INDEX_W-1:0]  rb_index,
    input  logic [icache_pkg::NUM_WAYS-1:0] hit_way,
    input  logic                            hit_touch,
    input  logic                            miss_pick,
    input  logic                            fill_touch,
    output logic [icache_pkg::WAY_W-1:0]    victim
);

    logic [icache_pkg::NUM_SETS-1:0][icache_pkg::NUM_WAYS-1:0] mru_q;
    logic [icache_pkg::NUM_WAYS-1:0] cur_mru;
    logic [icache_pkg::NUM_WAYS-1:0] victim_oh;
    logic [icache_pkg::NUM_WAYS-1:0] touch_oh;
    logic [icache_pkg::NUM_WAYS-1:0] merged;
    logic [icache_pkg::NUM_WAYS-1:0] next_mru;
    logic [icache_pkg::WAY_W-1:0]    pick;

    assign cur_mru   = mru_q[rb_index];
    assign victim_oh = {{(icache_pkg::NUM_WAYS-1){1'b0}}, 1'b1} << victim;
    assign touch_oh  = hit_touch ? hit_way : (fill_touch ? victim_oh : '0);

    // Touching the last clear way leaves only that way marked
    assign merged   = cur_mru | touch_oh;
    assign next_mru = (&merged) ? touch_oh : merged;

    // Lowest way not recently used
    always_comb begin
        pick = '0;
        for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!cur_mru[w]) begin
                pick = w[icache_pkg::WAY_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mru_q  <= '0;
            victim <= '0;
        end else begin
            if (hit_touch || fill_touch) begin
                mru_q[rb_index] <= next_mru;
            end
            // Held through REPLACE and REFILL
            if (miss_pick) begin
                victim <= pick;
            end
        end
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,
    input  icache_pkg::cache_addr_t req,
    output logic                    addr_ok,
    output logic                    data_ok,
    output mem_pkg::word_t          rdata,
    output mem_pkg::refill_req_t    mem_req,
    input  logic                    rd_rdy,
    input  mem_pkg::refill_ret_t    mem_ret
);

    logic [icache_pkg::TAG_W-1:0]    rb_tag;
    logic [icache_pkg::INDEX_W-1:0]  rb_index;
    logic [icache_pkg::OFFSET_W-1:0] rb_offset;
    logic [icache_pkg::NUM_WAYS-1:0] hit_way;
    logic [icache_pkg::WAY_W-1:0]    victim;
    logic                            lookup_rd;
    logic                            refill_we;
    logic                            hit_touch;
    logic                            miss_pick;
    logic                            fill_touch;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .req        (req),
        .hit_way    (hit_way),
        .rd_rdy     (rd_rdy),
        .mem_ret    (mem_ret),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .mem_req    (mem_req),
        .rb_tag     (rb_tag),
        .rb_index   (rb_index),
        .rb_offset  (rb_offset),
        .lookup_rd  (lookup_rd),
        .refill_we  (refill_we),
        .hit_touch  (hit_touch),
        .miss_pick  (miss_pick),
        .fill_touch (fill_touch)
    );

    tag_store u_tag (
        .clk       (clk),
        .resetn    (resetn),
        .lookup_rd (lookup_rd),
        .refill_we (refill_we),
        .req_index (req.index),
        .rb_index  (rb_index),
        .rb_tag    (rb_tag),
        .victim    (victim),
        .hit_way   (hit_way)
    );

    data_store u_data (
        .clk       (clk),
        .lookup_rd (lookup_rd),
        .refill_we (refill_we),
        .req_index (req.index),
        .rb_index  (rb_index),
        .rb_offset (rb_offset),
        .hit_way   (hit_way),
        .victim    (victim),
        .ret_data  (mem_ret.ret_data),
        .rdata     (rdata)
    );

    plru_repl u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .rb_index   (rb_index),
        .hit_way    (hit_way),
        .hit_touch  (hit_touch),
        .miss_pick  (miss_pick),
        .fill_touch (fill_touch),
        .victim     (victim)
    );

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: tb/icache_chk.sv
`timescale 1ns/1ps

module icache_chk (
    input logic                    clk,
    input logic                    resetn,
    input icache_pkg::ctrl_state_t state,
    input logic                    rd_req,
    input logic                    ret_valid,
    input logic                    addr_ok,
    input logic                    data_ok
);

    // Refill request only while waiting on memory
    a_req_in_replace: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_req |-> (state == icache_pkg::REPLACE)
    ) else $error("rd_req high outside REPLACE");

    a_refill_quiet: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == icache_pkg::REFILL && !ret_valid) |-> (!data_ok && !addr_ok)
    ) else $error("data_ok or addr_ok in REFILL before the line arrived");

endmodule

bind icache_ctrl icache_chk u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .state     (state),
    .rd_req    (mem_req.rd_req),
    .ret_valid (mem_ret.ret_valid),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok)
);

// File: tb/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

    localparam int CLK_NS       = 40;
    localparam int NUM_REQ      = 400;
    localparam int STALL_CYCLES = 10;
    localparam int LINE_BYTES   = 1 << icache_pkg::OFFSET_W;
    localparam int WATCHDOG_NS  = (NUM_REQ + 20) * 20 * CLK_NS;

    typedef struct packed {
        logic [31:0] addr;
        logic        hit;
        logic [31:0] cycle;
    } pending_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  gap;
    } issue_t;

    logic                    clk;
    logic                    resetn;
    logic                    valid;
    icache_pkg::cache_addr_t req;
    logic                    addr_ok;
    logic                    data_ok;
    mem_pkg::word_t          rdata;
    mem_pkg::refill_req_t    mem_req;
    logic                    rd_rdy;
    mem_pkg::refill_ret_t    mem_ret;

    // Reference model state per set
    logic [icache_pkg::TAG_W-1:0]    m_tag   [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic [icache_pkg::NUM_WAYS-1:0] m_valid [icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_WAYS-1:0] m_mru   [icache_pkg::NUM_SETS];

    pending_t    exp_q[$];
    issue_t      issue_q[$];
    logic [31:0] lcg_state;
    logic [31:0] cycle;
    logic [31:0] next_addr;
    logic [31:0] held_addr;
    logic [31:0] ret_addr;
    logic        took;
    logic        cpu_busy;
    logic        miss_active;
    logic        ret_pending;
    logic        rdy_armed;
    logic        stall_mode;
    int          gap_cnt;
    int          ret_wait;
    int          rdy_wait;
    int          miss_count;
    int          rdreq_cycles;
    int          value_errors;
    int          proto_errors;

    clk_gen u_clk (
        .clk (clk)
    );

    icache_top u_dut (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .req     (req),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .mem_req (mem_req),
        .rd_rdy  (rd_rdy),
        .mem_ret (mem_ret)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;
    endfunction

    function automatic mem_pkg::word_t mem_word(input logic [31:0] line_addr, input int k);
        return line_addr ^ (32'(k) * 32'h01010101) ^ 32'h5a5a0000;
    endfunction

    function automatic mem_pkg::line_t mem_line(input logic [31:0] line_addr);
        mem_pkg::line_t line;
        for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
            line[k] = mem_word(line_addr, k);
        end
        return line;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
    endfunction

    function automatic logic [31:0] make_addr(input int tag_n, input int set_n, input int word_n);
        return 32'h0040_0000 + 32'(tag_n * icache_pkg::NUM_SETS * LINE_BYTES)
            + 32'(set_n * LINE_BYTES) + 32'(word_n * 4);
    endfunction

    function automatic int model_find(input icache_pkg::cache_addr_t a);
        int way;
        way = -1;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic logic model_access(input icache_pkg::cache_addr_t a);
        int                              way;
        logic                            hit;
        logic [icache_pkg::NUM_WAYS-1:0] touch;
        way = model_find(a);
        hit = (way >= 0);
        if (!hit) begin
            // Fill goes to the lowest way with a clear MRU bit
            for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                if (way < 0 && !m_mru[a.index][w]) begin
                    way = w;
                end
            end
            m_tag[a.index][way]   = a.tag;
            m_valid[a.index][way] = 1'b1;
        end
        touch      = '0;
        touch[way] = 1'b1;
        // All other ways already marked starts a new round
        if ((m_mru[a.index] & ~touch) == ~touch) begin
            m_mru[a.index] = touch;
        end else begin
            m_mru[a.index][way] = 1'b1;
        end
        return hit;
    endfunction

    task automatic push_req(input logic [31:0] addr, input int gap);
        issue_t item;
        item.addr = addr;
        item.gap  = 4'(gap);
        issue_q.push_back(item);
    endtask

    task automatic drive_memory();
        mem_ret.ret_valid = 1'b0;
        mem_ret.ret_data  = '0;
        if (ret_pending) begin
            if (ret_wait == 0) begin
                mem_ret.ret_valid = 1'b1;
                mem_ret.ret_data  = mem_line(ret_addr);
                ret_pending       = 1'b0;
            end else begin
                ret_wait--;
            end
        end
        if (mem_req.rd_req) begin
            if (!rdy_armed) begin
                rdy_armed = 1'b1;
                rdy_wait  = stall_mode ? STALL_CYCLES : rand_below(6);
            end
            if (rdy_wait == 0) begin
                rd_rdy = 1'b1;
            end else begin
                rd_rdy = 1'b0;
                rdy_wait--;
            end
        end else begin
            rd_rdy    = 1'b0;
            rdy_armed = 1'b0;
        end
    endtask

    task automatic drive_cpu();
        issue_t item;
        if (took) begin
            valid    = 1'b0;
            cpu_busy = 1'b0;
            took     = 1'b0;
        end
        if (!cpu_busy && issue_q.size() > 0) begin
            item      = issue_q.pop_front();
            next_addr = item.addr;
            gap_cnt   = int'(item.gap);
            cpu_busy  = 1'b1;
        end
        if (cpu_busy && !valid) begin
            if (gap_cnt == 0) begin
                valid = 1'b1;
                req   = icache_pkg::cache_addr_t'(next_addr);
            end else begin
                gap_cnt--;
            end
        end
    endtask

    task automatic check_outputs();
        pending_t       entry;
        mem_pkg::word_t exp_word;
        if (mem_req.rd_req) begin
            rdreq_cycles++;
            if (!miss_active) begin
                assert (exp_q.size() > 0 && !exp_q[0].hit) else begin
                    $display("rd_req raised at %0t without a predicted miss", $time);
                    proto_errors++;
                end
                if (exp_q.size() > 0) begin
                    assert (mem_req.rd_addr == line_of(exp_q[0].addr)) else begin
                        $display("FAILED at %0t: rd_addr expected %08h got %08h",
                                 $time, line_of(exp_q[0].addr), mem_req.rd_addr);
                        value_errors++;
                    end
                end
                miss_active = 1'b1;
                held_addr   = mem_req.rd_addr;
            end else begin
                assert (mem_req.rd_addr == held_addr) else begin
                    $display("FAILED at %0t: rd_addr expected %08h got %08h",
                             $time, held_addr, mem_req.rd_addr);
                    value_errors++;
                end
            end
        end
        if (mem_req.rd_req && rd_rdy) begin
            miss_count++;
            ret_pending = 1'b1;
            ret_wait    = rand_below(6);
            ret_addr    = mem_req.rd_addr;
        end
        if (miss_active && valid) begin
            assert (!addr_ok) else begin
                $display("addr_ok raised at %0t while a miss was outstanding", $time);
                proto_errors++;
            end
        end
        if (data_ok) begin
            if (exp_q.size() == 0) begin
                $display("data_ok at %0t with no request outstanding", $time);
                proto_errors++;
            end else begin
                entry    = exp_q.pop_front();
                exp_word = mem_word(line_of(entry.addr),
                                    int'(entry.addr[icache_pkg::OFFSET_W-1:2]));
                assert (rdata == exp_word) else begin
                    $display("FAILED at %0t: rdata expected %08h got %08h",
                             $time, exp_word, rdata);
                    value_errors++;
                end
                if (entry.hit) begin
                    assert (cycle == entry.cycle + 1 && !miss_active) else begin
                        $display("Predicted hit at %0t did not complete in one cycle", $time);
                        proto_errors++;
                    end
                end else begin
                    assert (miss_active && mem_ret.ret_valid) else begin
                        $display("Predicted miss at %0t completed without a refill", $time);
                        proto_errors++;
                    end
                    miss_active = 1'b0;
                end
            end
        end else if (exp_q.size() > 0 && exp_q[0].hit && cycle == exp_q[0].cycle + 1) begin
            $display("No data_ok at %0t for a predicted hit", $time);
            proto_errors++;
        end
        if (valid && addr_ok) begin
            entry.addr  = req;
            entry.hit   = model_access(req);
            entry.cycle = cycle;
            exp_q.push_back(entry);
            took = 1'b1;
        end
    endtask

    // Inputs change on the falling edge and outputs are sampled once settled
    task automatic run_cycle();
        @(negedge clk);
        cycle = cycle + 1;
        drive_memory();
        drive_cpu();
        #5;
        check_outputs();
    endtask

    task automatic drain();
        while (issue_q.size() > 0 || cpu_busy || exp_q.size() > 0) begin
            run_cycle();
        end
    endtask

    initial begin
        logic [31:0] plru_lines [5];
        int          evicted;
        int          count_before;
        int          n;
        int          word_n;
        int          gap;
        resetn       = 1'b0;
        valid        = 1'b0;
        req          = '0;
        rd_rdy       = 1'b0;
        mem_ret      = '0;
        lcg_state    = 32'hd929;
        cycle        = '0;
        next_addr    = '0;
        held_addr    = '0;
        ret_addr     = '0;
        took         = 1'b0;
        cpu_busy     = 1'b0;
        miss_active  = 1'b0;
        ret_pending  = 1'b0;
        rdy_armed    = 1'b0;
        stall_mode   = 1'b0;
        gap_cnt      = 0;
        ret_wait     = 0;
        rdy_wait     = 0;
        miss_count   = 0;
        rdreq_cycles = 0;
        value_errors = 0;
        proto_errors = 0;
        for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
            m_valid[s] = '0;
            m_mru[s]   = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #5;
        assert (!addr_ok && !data_ok && !mem_req.rd_req) else begin
            $display("Outputs not idle after reset");
            proto_errors++;
        end

        // Five lines into set 15 with hits in between
        for (int i = 0; i < 5; i++) begin
            plru_lines[i] = make_addr(100 + i, 15, i % 4);
        end
        push_req(plru_lines[0], 0);
        push_req(plru_lines[1], 1);
        push_req(plru_lines[0], 0);
        push_req(plru_lines[2], 2);
        push_req(plru_lines[3], 0);
        push_req(plru_lines[1], 0);
        push_req(plru_lines[4], 1);
        drain();
        evicted = 0;
        for (int i = 0; i < 5; i++) begin
            if (model_find(icache_pkg::cache_addr_t'(plru_lines[i])) < 0) begin
                evicted = i;
            end
        end
        for (int i = 0; i < 5; i++) begin
            if (i != evicted) begin
                push_req(plru_lines[i], 0);
            end
        end
        push_req(plru_lines[evicted], 0);
        count_before = miss_count;
        drain();
        assert (miss_count - count_before == 1) else begin
            $display("Re-request of set 15 caused %0d refills, expected one",
                     miss_count - count_before);
            proto_errors++;
        end

        // Memory holds rd_rdy low while a second request waits
        stall_mode   = 1'b1;
        count_before = rdreq_cycles;
        push_req(make_addr(200, 14, 0), 0);
        push_req(make_addr(200, 14, 1), 0);
        drain();
        stall_mode = 1'b0;
        assert (rdreq_cycles - count_before >= STALL_CYCLES + 1) else begin
            $display("rd_req did not stay high through the memory stall");
            proto_errors++;
        end

        // Random traffic over 48 lines in 8 sets
        repeat (NUM_REQ) begin
            n      = rand_below(48);
            word_n = rand_below(4);
            gap    = rand_below(4);
            push_req(make_addr(n / 8, n % 8, word_n), gap);
        end
        drain();

        $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d requests still outstanding",
                 WATCHDOG_NS, exp_q.size() + issue_q.size());
        $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim.f
source/icache_pkg.sv
source/mem_pkg.sv
source/icache_ctrl.sv
source/tag_store.sv
source/data_store.sv
source/plru_repl.sv
source/icache_top.sv
tb/clk_gen.sv
tb/icache_chk.sv
tb/tb_icache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f sim.f -o tb_icache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_icache 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
